/* hdl/mem_port_switch_settings.svh */
//====================================================================
// Width and count settings for the memory port switch.
// Included by the package and by any module that sizes adapter arrays.
// Change a width here and the package types follow it.
//====================================================================

`ifndef MEM_PORT_SWITCH_SETTINGS_SVH
`define MEM_PORT_SWITCH_SETTINGS_SVH

// Request address width in bits
`define MPS_ADDR_W 32

// Response data width in bits
// Echo target returns the address as data, so keep this equal to the address width
`define MPS_DATA_W 32

// Transaction ID width, carried unchanged from request to response
`define MPS_ID_W 4

// Performance counter width
// Shared by the request, response, outstanding and latency sum counters
`define MPS_CNT_W 32

// External adapter ports
// Index 0 is AXI4, 1 is CHI, 2 is TileLink
// Echo target is internal and has no port
`define MPS_NUM_ADAPTERS 3

`endif

/* hdl/mem_port_switch_pkg.sv */
//====================================================================
// Shared types for the memory port switch and its testbench.
// Vector widths come from the settings header.
// Import with a wildcard in the module header.
//====================================================================

`include "mem_port_switch_settings.svh"

package mem_port_switch_pkg;

    // Request address
    typedef logic [`MPS_ADDR_W-1:0] addr_t;

    // Response data
    typedef logic [`MPS_DATA_W-1:0] data_t;

    // Transaction ID
    typedef logic [`MPS_ID_W-1:0] txn_id_t;

    // Performance counter value
    typedef logic [`MPS_CNT_W-1:0] cnt_t;

    // Configuration and status word
    // Config layout: [1:0] target, [2] enable, [3] debug, [15:8] protocol config
    typedef logic [31:0] cfg_word_t;

    // Downstream target select, encoded as cfg bits 1:0
    // Adapter targets double as adapter port index
    typedef enum logic [1:0] {
        TARGET_AXI4     = 2'd0,
        TARGET_CHI      = 2'd1,
        TARGET_TILELINK = 2'd2,
        TARGET_ECHO     = 2'd3
    } target_e;

endpackage

/* hdl/mem_req_stage.sv */
//====================================================================
// Configuration decode and single-entry request holding stage.
// Registers target and enable from the config word, accepts one
// request per cycle upstream and holds it until the router drains it.
//====================================================================

module mem_req_stage
    import mem_port_switch_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Configuration word, sampled every cycle
    input  cfg_word_t cfg_i,

    // Upstream request
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  addr_t     req_addr_i,
    input  txn_id_t   req_id_i,

    // Held request towards the router
    input  logic      stage_drain_i,
    output logic      stage_valid_o,
    output addr_t     stage_addr_o,
    output txn_id_t   stage_id_o,

    // Registered configuration
    output target_e   sel_target_o,
    output logic      sw_enable_o
);

    //====================================================================
    // Configuration registers
    //====================================================================

    target_e target_q;
    logic    enable_q;

    // Target and enable take effect one cycle after cfg_i changes
    // Reset selects AXI4 with the switch disabled
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            target_q <= TARGET_AXI4;
            enable_q <= 1'b0;
        end else begin
            target_q <= target_e'(cfg_i[1:0]);
            enable_q <= cfg_i[2];
        end
    end

    //====================================================================
    // Request holding stage
    //====================================================================

    logic    valid_q;
    addr_t   addr_q;
    txn_id_t id_q;
    logic    accept;

    // Room when empty or when the held request leaves this edge
    assign req_ready_o = enable_q & (~valid_q | stage_drain_i);
    assign accept      = req_valid_i & req_ready_o;

    // Occupancy flag
    // Load wins over drain so back-to-back requests keep the stage full
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (stage_drain_i) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only loads on an upstream transfer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= req_addr_i;
            id_q   <= req_id_i;
        end
    end

    assign stage_valid_o = valid_q;
    assign stage_addr_o  = addr_q;
    assign stage_id_o    = id_q;
    assign sel_target_o  = target_q;
    assign sw_enable_o   = enable_q;

endmodule

/* hdl/mem_rsp_router.sv */
//====================================================================
// Request steering and response return for the memory port switch.
// Sends the held request to the selected adapter, or answers it
// directly for the echo target. Purely combinational.
//====================================================================

`include "mem_port_switch_settings.svh"

module mem_rsp_router
    import mem_port_switch_pkg::*;
(
    // Selection and held request
    input  target_e                      sel_target_i,
    input  logic                         stage_valid_i,
    input  addr_t                        stage_addr_i,
    input  txn_id_t                      stage_id_i,
    output logic                         stage_drain_o,

    // Adapter request side
    output logic [`MPS_NUM_ADAPTERS-1:0] adp_req_valid_o,
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_req_ready_i,
    output addr_t                        adp_req_addr_o,
    output txn_id_t                      adp_req_id_o,

    // Adapter response side
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_valid_i,
    output logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_ready_o,
    input  data_t                        adp_rsp_data_i [`MPS_NUM_ADAPTERS],
    input  txn_id_t                      adp_rsp_id_i [`MPS_NUM_ADAPTERS],
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_error_i,

    // Upstream response
    output logic                         rsp_valid_o,
    input  logic                         rsp_ready_i,
    output data_t                        rsp_data_o,
    output txn_id_t                      rsp_id_o,
    output logic                         rsp_error_o
);

    //====================================================================
    // Request steering
    //====================================================================

    // Address and ID are shared, only valid is steered
    assign adp_req_addr_o = stage_addr_i;
    assign adp_req_id_o   = stage_id_i;

    always_comb begin
        adp_req_valid_o = '0;
        stage_drain_o   = 1'b0;
        for (int i = 0; i < `MPS_NUM_ADAPTERS; i++) begin
            if (sel_target_i == target_e'(i)) begin
                adp_req_valid_o[i] = stage_valid_i;
                stage_drain_o      = stage_valid_i & adp_req_ready_i[i];
            end
        end
        // Echo request leaves when its response is taken upstream
        if (sel_target_i == TARGET_ECHO) begin
            stage_drain_o = stage_valid_i & rsp_ready_i;
        end
    end

    //====================================================================
    // Response return
    //====================================================================

    always_comb begin
        rsp_valid_o     = 1'b0;
        rsp_data_o      = '0;
        rsp_id_o        = '0;
        rsp_error_o     = 1'b0;
        adp_rsp_ready_o = '0;
        if (sel_target_i == TARGET_ECHO) begin
            // Echo answers from the stage, data is the address
            rsp_valid_o = stage_valid_i;
            rsp_data_o  = data_t'(stage_addr_i);
            rsp_id_o    = stage_id_i;
        end else begin
            for (int i = 0; i < `MPS_NUM_ADAPTERS; i++) begin
                if (sel_target_i == target_e'(i)) begin
                    rsp_valid_o        = adp_rsp_valid_i[i];
                    rsp_data_o         = adp_rsp_data_i[i];
                    rsp_id_o           = adp_rsp_id_i[i];
                    rsp_error_o        = adp_rsp_error_i[i];
                    // Only the selected adapter sees upstream ready
                    adp_rsp_ready_o[i] = rsp_ready_i;
                end
            end
        end
    end

endmodule

/* hdl/mem_perf_monitor.sv */
//====================================================================
// Performance monitor for the memory port switch.
// Counts upstream request and response transfers, accumulates latency
// and reports the average and a status word built from the config.
//====================================================================

module mem_perf_monitor
    import mem_port_switch_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Observed configuration
    input  cfg_word_t cfg_i,
    input  logic      sw_enable_i,

    // Observed upstream handshakes
    input  logic      req_valid_i,
    input  logic      req_ready_i,
    input  logic      rsp_valid_i,
    input  logic      rsp_ready_i,

    // Results
    output cnt_t      txn_count_o,
    output cnt_t      rsp_count_o,
    output cnt_t      latency_avg_o,
    output cfg_word_t status_o
);

    //====================================================================
    // Counters
    //====================================================================

    logic req_hs;
    logic rsp_hs;
    cnt_t txn_q;
    cnt_t rsp_q;
    cnt_t outst_q;
    cnt_t lat_sum_q;

    assign req_hs = req_valid_i & req_ready_i;
    assign rsp_hs = rsp_valid_i & rsp_ready_i;

    // Latency sum grows by the requests outstanding before each edge
    // A request accepted at edge a and answered at edge r adds r - a
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            txn_q     <= '0;
            rsp_q     <= '0;
            outst_q   <= '0;
            lat_sum_q <= '0;
        end else begin
            if (req_hs) begin
                txn_q <= txn_q + cnt_t'(1);
            end
            if (rsp_hs) begin
                rsp_q <= rsp_q + cnt_t'(1);
            end
            outst_q   <= outst_q + cnt_t'(req_hs) - cnt_t'(rsp_hs);
            lat_sum_q <= lat_sum_q + outst_q;
        end
    end

    //====================================================================
    // Average and status
    //====================================================================

    // Floor of sum over completed responses
    // Zero until the first response completes
    always_comb begin
        if (rsp_q == '0) begin
            latency_avg_o = '0;
        end else begin
            latency_avg_o = lat_sum_q / rsp_q;
        end
    end

    assign txn_count_o = txn_q;
    assign rsp_count_o = rsp_q;

    // Debug and protocol config are only reflected here
    assign status_o = {
        8'h00,          // reserved
        txn_q[23:16],
        sw_enable_i,
        cfg_i[3],       // debug
        2'b00,          // reserved
        txn_q[11:8],
        cfg_i[15:10],   // upper protocol config
        cfg_i[1:0]      // requested target
    };

endmodule

/* hdl/mem_port_switch.sv */
//====================================================================
// Memory request switch, top level.
// Routes one valid/ready request/response port to the AXI4, CHI or
// TileLink adapter port, or to the internal echo responder, as the
// config word selects. Change the config only with nothing in flight.
//====================================================================

`include "mem_port_switch_settings.svh"

module mem_port_switch
    import mem_port_switch_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_ni,

    // Target [1:0], enable [2], debug [3], protocol config [15:8]
    input  cfg_word_t                    cfg_i,

    // Upstream request
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  addr_t                        req_addr_i,
    input  txn_id_t                      req_id_i,

    // Upstream response
    output logic                         rsp_valid_o,
    input  logic                         rsp_ready_i,
    output data_t                        rsp_data_o,
    output txn_id_t                      rsp_id_o,
    output logic                         rsp_error_o,

    // Adapter requests, index 0 AXI4, 1 CHI, 2 TileLink
    output logic [`MPS_NUM_ADAPTERS-1:0] adp_req_valid_o,
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_req_ready_i,
    output addr_t                        adp_req_addr_o,
    output txn_id_t                      adp_req_id_o,

    // Adapter responses
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_valid_i,
    output logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_ready_o,
    input  data_t                        adp_rsp_data_i [`MPS_NUM_ADAPTERS],
    input  txn_id_t                      adp_rsp_id_i [`MPS_NUM_ADAPTERS],
    input  logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_error_i,

    // Performance monitor
    output cnt_t                         txn_count_o,
    output cnt_t                         rsp_count_o,
    output cnt_t                         latency_avg_o,
    output cfg_word_t                    status_o
);

    // Stage to router
    logic    stage_valid;
    addr_t   stage_addr;
    txn_id_t stage_id;
    target_e sel_target;
    logic    sw_enable;
    // Router back to stage
    logic    stage_drain;

    //====================================================================
    // Config decode and request stage
    //====================================================================

    mem_req_stage i_req_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cfg_i         (cfg_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_addr_i    (req_addr_i),
        .req_id_i      (req_id_i),
        .stage_drain_i (stage_drain),
        .stage_valid_o (stage_valid),
        .stage_addr_o  (stage_addr),
        .stage_id_o    (stage_id),
        .sel_target_o  (sel_target),
        .sw_enable_o   (sw_enable)
    );

    //====================================================================
    // Steering and response return
    //====================================================================

    mem_rsp_router i_rsp_router (
        .sel_target_i    (sel_target),
        .stage_valid_i   (stage_valid),
        .stage_addr_i    (stage_addr),
        .stage_id_i      (stage_id),
        .stage_drain_o   (stage_drain),
        .adp_req_valid_o (adp_req_valid_o),
        .adp_req_ready_i (adp_req_ready_i),
        .adp_req_addr_o  (adp_req_addr_o),
        .adp_req_id_o    (adp_req_id_o),
        .adp_rsp_valid_i (adp_rsp_valid_i),
        .adp_rsp_ready_o (adp_rsp_ready_o),
        .adp_rsp_data_i  (adp_rsp_data_i),
        .adp_rsp_id_i    (adp_rsp_id_i),
        .adp_rsp_error_i (adp_rsp_error_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_data_o      (rsp_data_o),
        .rsp_id_o        (rsp_id_o),
        .rsp_error_o     (rsp_error_o)
    );

    //====================================================================
    // Monitor, watches the upstream handshakes
    //====================================================================

    mem_perf_monitor i_perf_monitor (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cfg_i         (cfg_i),
        .sw_enable_i   (sw_enable),
        .req_valid_i   (req_valid_i),
        .req_ready_i   (req_ready_o),
        .rsp_valid_i   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .txn_count_o   (txn_count_o),
        .rsp_count_o   (rsp_count_o),
        .latency_avg_o (latency_avg_o),
        .status_o      (status_o)
    );

endmodule

/* verif/mem_port_switch_tb.sv */
//======================================================================
// Testbench for the memory port switch.
// Reads requests and expected responses from the golden file, models
// the three adapters and checks routing, ordering, monitor and status.
//======================================================================

`include "mem_port_switch_settings.svh"

module mem_port_switch_tb
    import mem_port_switch_pkg::*;
;
    logic clk_i;
    logic rst_ni;
    cfg_word_t cfg_i;
    logic req_valid_i;
    logic req_ready_o;
    addr_t req_addr_i;
    txn_id_t req_id_i;
    logic rsp_valid_o;
    logic rsp_ready_i;
    data_t rsp_data_o;
    txn_id_t rsp_id_o;
    logic rsp_error_o;
    logic [`MPS_NUM_ADAPTERS-1:0] adp_req_valid_o;
    logic [`MPS_NUM_ADAPTERS-1:0] adp_req_ready_i;
    addr_t adp_req_addr_o;
    txn_id_t adp_req_id_o;
    logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_valid_i;
    logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_ready_o;
    data_t adp_rsp_data_i [`MPS_NUM_ADAPTERS];
    txn_id_t adp_rsp_id_i [`MPS_NUM_ADAPTERS];
    logic [`MPS_NUM_ADAPTERS-1:0] adp_rsp_error_i;
    cnt_t txn_count_o;
    cnt_t rsp_count_o;
    cnt_t latency_avg_o;
    cfg_word_t status_o;

    // Golden vectors
    string v_name [32];
    cfg_word_t v_cfg [32];
    addr_t v_addr [32];
    txn_id_t v_id [32];
    data_t v_data [32];
    logic v_err [32];
    int n_vec;

    // Reference state
    logic [31:0] lfsr_q = 32'he21849e1;
    cnt_t cyc = '0;
    cnt_t ref_txn;
    cnt_t ref_rsp;
    cnt_t ref_lat;
    cnt_t accept_q [$];
    addr_t adp_q [`MPS_NUM_ADAPTERS][$];
    txn_id_t adp_id_q [`MPS_NUM_ADAPTERS][$];
    logic rsp_hold [`MPS_NUM_ADAPTERS];
    target_e cur_target;
    logic echo_mode;
    int adp_idx;
    int check_errs;
    int other_errs;

    mem_port_switch i_dut (.*);

    // 100 unit clock period
    always #50 clk_i = ~clk_i;

    always @(negedge clk_i) cyc <= cyc + cnt_t'(1);

    //======================================================================
    // Random bits and reference helpers
    //======================================================================

    // Fibonacci LFSR with taps 32 22 2 1
    // Stepped once per random bit
    function automatic logic rand_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    // Fixed tag each adapter model XORs into its data
    function automatic data_t adapter_tag(input int a);
        case (a)
            0: return 32'h1111_0000;
            1: return 32'h0000_2222;
            default: return 32'h3300_0033;
        endcase
    endfunction

    // Status word layout of the monitor
    function automatic cfg_word_t expected_status(input cfg_word_t c, input cnt_t t);
        return {8'h00, t[23:16], c[2], c[3], 2'b00, t[11:8], c[15:10], c[1:0]};
    endfunction

    //======================================================================
    // Compare tasks
    //======================================================================

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input txn_id_t exp, input txn_id_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input cfg_word_t exp, input cfg_word_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d check failures, %0d other failures", check_errs, other_errs);
    endtask

    // Ends the run after a hang or a missing file
    task automatic abort_run(input string what);
        other_errs++;
        $display("Run stopped: %s", what);
        print_counts();
        $display("Simulation FAILED");
        $finish;
    endtask

    //======================================================================
    // Adapter models
    //======================================================================

    // Accept and pop at the rising edge
    // Routing of request valid and response ready checked on every edge
    always @(posedge clk_i) begin
        for (int a = 0; a < `MPS_NUM_ADAPTERS; a++) begin
            if (adp_req_valid_o[a] && (echo_mode || int'(cur_target) != a)) begin
                other_errs++;
                $display("Request valid on adapter %0d which is not selected", a);
            end
            if (adp_rsp_ready_o[a] && (echo_mode || int'(cur_target) != a)) begin
                other_errs++;
                $display("Response ready on adapter %0d which is not selected", a);
            end
            if (adp_req_valid_o[a] && adp_req_ready_i[a]) begin
                check_addr({v_name[adp_idx], "_adp_addr"}, v_addr[adp_idx], adp_req_addr_o);
                check_id({v_name[adp_idx], "_adp_id"}, v_id[adp_idx], adp_req_id_o);
                adp_idx++;
                adp_q[a].push_back(adp_req_addr_o);
                adp_id_q[a].push_back(adp_req_id_o);
            end
            if (adp_rsp_valid_i[a] && adp_rsp_ready_o[a]) begin
                void'(adp_q[a].pop_front());
                void'(adp_id_q[a].pop_front());
                rsp_hold[a] = 1'b0;
            end
        end
    end

    // Random ready and in-order responses that hold until taken
    always @(negedge clk_i) begin
        for (int a = 0; a < `MPS_NUM_ADAPTERS; a++) begin
            adp_req_ready_i[a] = rand_bit();
            if (!rsp_hold[a] && adp_q[a].size() > 0 && rand_bit()) begin
                rsp_hold[a] = 1'b1;
            end
            adp_rsp_valid_i[a] = rsp_hold[a];
            if (rsp_hold[a]) begin
                adp_rsp_data_i[a]  = data_t'(adp_q[a][0]) ^ adapter_tag(a);
                adp_rsp_id_i[a]    = adp_id_q[a][0];
                adp_rsp_error_i[a] = adp_q[a][0][31];
            end
        end
    end

    //======================================================================
    // Stimulus tasks
    //======================================================================

    task automatic load_vectors();
        int fd;
        int r;
        string line;
        string nm;
        cfg_word_t c;
        addr_t ad;
        txn_id_t id;
        data_t d;
        logic e;
        n_vec = 0;
        fd = $fopen("verif/mem_port_switch_golden.txt", "r");
        if (fd == 0) begin
            abort_run("golden file could not be opened");
        end else begin
            while (!$feof(fd) && n_vec < 32) begin
                r = $fgets(line, fd);
                // Skip comment and empty lines
                if (r > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    r = $sscanf(line, "%s %h %h %h %h %h", nm, c, ad, id, d, e);
                    if (r == 6) begin
                        v_name[n_vec] = nm;
                        v_cfg[n_vec]  = c;
                        v_addr[n_vec] = ad;
                        v_id[n_vec]   = id;
                        v_data[n_vec] = d;
                        v_err[n_vec]  = e;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            if (n_vec == 0) begin
                abort_run("golden file holds no vectors");
            end
        end
    endtask

    task automatic drive_requests(input int s, input int e);
        int tmo;
        logic done;
        @(negedge clk_i);
        for (int k = s; k < e; k++) begin
            // Random idle gaps except for echo, whose timing must stay exact
            if (!echo_mode && rand_bit()) begin
                req_valid_i = 1'b0;
                @(negedge clk_i);
            end
            req_valid_i = 1'b1;
            req_addr_i  = v_addr[k];
            req_id_i    = v_id[k];
            done = 1'b0;
            tmo  = 0;
            while (!done) begin
                @(posedge clk_i);
                if (req_ready_o) begin
                    done = 1'b1;
                    accept_q.push_back(cyc);
                    ref_txn++;
                end else if (++tmo > 200) begin
                    abort_run("request was never accepted");
                end
            end
            @(negedge clk_i);
        end
        req_valid_i = 1'b0;
    endtask

    task automatic collect_responses(input int s, input int e);
        int k;
        int tmo;
        cnt_t lat;
        k = s;
        tmo = 0;
        while (k < e) begin
            @(negedge clk_i);
            rsp_ready_i = echo_mode ? 1'b1 : rand_bit();
            @(posedge clk_i);
            if (rsp_valid_o && rsp_ready_i) begin
                check_data({v_name[k], "_data"}, v_data[k], rsp_data_o);
                check_id({v_name[k], "_id"}, v_id[k], rsp_id_o);
                check_flag({v_name[k], "_error"}, v_err[k], rsp_error_o);
                if (accept_q.size() == 0) begin
                    other_errs++;
                    $display("Response arrived with no request outstanding");
                end else begin
                    lat = cyc - accept_q.pop_front();
                    ref_lat += lat;
                    if (echo_mode) begin
                        check_cnt({v_name[k], "_echo_latency"}, cnt_t'(1), lat);
                    end
                end
                ref_rsp++;
                k++;
                tmo = 0;
            end else if (++tmo > 500) begin
                abort_run("response never arrived");
            end
        end
        @(negedge clk_i);
        rsp_ready_i = 1'b0;
    endtask

    task automatic check_monitor(input string name);
        check_cnt({name, "_txn_count"}, ref_txn, txn_count_o);
        check_cnt({name, "_rsp_count"}, ref_rsp, rsp_count_o);
        check_cnt({name, "_latency_avg"}, (ref_rsp == '0) ? '0 : ref_lat / ref_rsp,
                  latency_avg_o);
        check_status({name, "_status"}, expected_status(cfg_i, ref_txn), status_o);
    endtask

    // Control outputs low and counters clear
    task automatic check_reset_state(input string name);
        check_flag({name, "_req_ready"}, 1'b0, req_ready_o);
        check_flag({name, "_rsp_valid"}, 1'b0, rsp_valid_o);
        check_cnt({name, "_adp_req_valid"}, '0, cnt_t'(adp_req_valid_o));
        check_cnt({name, "_adp_rsp_ready"}, '0, cnt_t'(adp_rsp_ready_o));
        check_cnt({name, "_txn_count"}, '0, txn_count_o);
        check_cnt({name, "_rsp_count"}, '0, rsp_count_o);
        check_cnt({name, "_latency_avg"}, '0, latency_avg_o);
    endtask

    task automatic run_group(input int s, input int e);
        @(negedge clk_i);
        // Only changed with nothing outstanding
        cfg_i      = v_cfg[s];
        cur_target = target_e'(v_cfg[s][1:0]);
        echo_mode  = (cur_target == TARGET_ECHO);
        adp_idx    = s;
        repeat (2) @(negedge clk_i);
        fork
            drive_requests(s, e);
            collect_responses(s, e);
        join
        @(negedge clk_i);
        check_monitor(v_name[s]);
    endtask

    //======================================================================
    // Main sequence
    //======================================================================

    initial begin
        int s;
        int e;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        cfg_i = '0;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        req_id_i = '0;
        rsp_ready_i = 1'b0;
        adp_req_ready_i = '0;
        adp_rsp_valid_i = '0;
        adp_rsp_error_i = '0;
        for (int a = 0; a < `MPS_NUM_ADAPTERS; a++) begin
            adp_rsp_data_i[a] = '0;
            adp_rsp_id_i[a]   = '0;
            rsp_hold[a]       = 1'b0;
        end
        cur_target = TARGET_AXI4;
        echo_mode = 1'b0;
        adp_idx = 0;
        ref_txn = '0;
        ref_rsp = '0;
        ref_lat = '0;
        check_errs = 0;
        other_errs = 0;
        load_vectors();

        repeat (16) @(negedge clk_i);
        check_reset_state("reset_start");
        rst_ni = 1'b1;

        // One test per run of lines with the same name
        s = 0;
        while (s < n_vec) begin
            e = s;
            while (e < n_vec && v_name[e] == v_name[s]) e++;
            run_group(s, e);
            s = e;
        end

        // Disabled switch holds off every request
        @(negedge clk_i);
        cfg_i = 32'h0000_0000;
        repeat (2) @(negedge clk_i);
        req_valid_i = 1'b1;
        req_addr_i  = 32'h0000_0BAD;
        repeat (8) begin
            @(posedge clk_i);
            check_flag("disabled_req_ready", 1'b0, req_ready_o);
            check_cnt("disabled_adp_valid", '0, cnt_t'(adp_req_valid_o));
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
        check_monitor("disabled");

        // Reset in the middle of the run clears everything
        rst_ni = 1'b0;
        ref_txn = '0;
        ref_rsp = '0;
        ref_lat = '0;
        repeat (2) @(negedge clk_i);
        check_reset_state("reset_again");
        rst_ni = 1'b1;
        repeat (2) @(negedge clk_i);
        check_monitor("after_reset");

        print_counts();
        if (check_errs == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* mem_port_switch.f */
+incdir+hdl
hdl/mem_port_switch_pkg.sv
hdl/mem_req_stage.sv
hdl/mem_rsp_router.sv
hdl/mem_perf_monitor.sv
hdl/mem_port_switch.sv
verif/mem_port_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory port switch testbench with Verilator.
# Exit status is non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary -f mem_port_switch.f --top-module mem_port_switch_tb \
    --Mdir obj_dir -o mem_port_switch_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/mem_port_switch_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulator returned status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

/* verif/mem_port_switch_golden.txt */
# name cfg_word addr id exp_data exp_error (all hex except name)
# one request per line, lines with the same name form one test
axi4 0000A50C 00001000 1 11111000 0
axi4 0000A50C 80002004 2 91112004 1
axi4 0000A50C 12345678 3 03255678 0
axi4 0000A50C 0000ABCC 4 1111ABCC 0
chi 00000005 00004000 5 00006222 0
chi 00000005 C0000010 6 C0002232 1
chi 00000005 7FFF0000 7 7FFF2222 0
chi 00000005 00001111 8 00003333 0
tilelink 0000FC0E 00000100 9 33000133 0
tilelink 0000FC0E 90000000 A A3000033 1
tilelink 0000FC0E 00FF00FF B 33FF00CC 0
tilelink 0000FC0E 0A0B0C0D C 390B0C3E 0
echo 00000007 DEADBEEF D DEADBEEF 0
echo 00000007 00000042 E 00000042 0
echo 00000007 CAFE0000 F CAFE0000 0
echo 00000007 00000001 0 00000001 0
axi4_nodebug 00000004 80000000 1 91110000 1
axi4_nodebug 00000004 00000000 2 11110000 0
